// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --timescale 1ns/1ns -Wno-fatal
TOP       ?= ex_mem_tb
FILELIST  ?= ex_mem.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Regression passed$$"

clean:
	rm -rf $(OBJ_DIR)

// File: design/bus_timeout_timer.sv
`timescale 1ns/1ns
`include "ex_mem_defs.svh"

module bus_timeout_timer (
    input  logic clock,
    input  logic reset,
    input  logic timer_run,
    output logic expired
);

    localparam int CNT_W = $clog2(`BUS_TIMEOUT + 1);

    logic [CNT_W-1:0] wait_count;

    assign expired = (wait_count == CNT_W'(`BUS_TIMEOUT));

    // the count holds at the limit until the bus cycle is dropped.
    always_ff @(posedge clock) begin
        if (reset) begin
            wait_count <= '0;
        end else if (!timer_run) begin
            wait_count <= '0;
        end else if (!expired) begin
            wait_count <= wait_count + 1'b1;
        end
    end

endmodule

// File: design/data_mem_wb.sv
`timescale 1ns/1ns
`include "ex_mem_defs.svh"

module data_mem_wb (
    input  logic        clock,
    input  logic        reset,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [29:0] wb_adr,
    input  logic [31:0] wb_dat_w,
    output logic [31:0] wb_dat_r,
    output logic        wb_ack
);

    localparam int IDX_W  = $clog2(`MEM_WORDS);
    localparam int WAIT_W = $clog2(`MEM_WAIT + 2);

    logic [31:0]       mem [`MEM_WORDS];
    logic [WAIT_W-1:0] wait_count;
    logic [IDX_W-1:0]  word_idx;
    logic              access;
    logic              in_range;

    assign access = wb_cyc && wb_stb;
    assign in_range = (wb_adr < 30'(`MEM_WORDS));
    assign word_idx = wb_adr[IDX_W-1:0];

    // addresses past the end of the memory are left hanging on purpose.
    assign wb_ack = access && in_range && (wait_count == WAIT_W'(`MEM_WAIT));
    assign wb_dat_r = in_range ? mem[word_idx] : '0;

    always_ff @(posedge clock) begin
        if (reset) begin
            wait_count <= '0;
        end else if (!access || wb_ack) begin
            wait_count <= '0;
        end else if (wait_count != WAIT_W'(`MEM_WAIT)) begin
            wait_count <= wait_count + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (wb_ack && wb_we) begin
            mem[word_idx] <= wb_dat_w;
        end
    end

endmodule

// File: design/ex_mem_pkg.sv
package ex_mem_pkg;

    // ********************************************************************
    // execute packet types
    // ********************************************************************

    typedef enum logic [1:0] {
        OP_ALU   = 2'd0,
        OP_LOAD  = 2'd1,
        OP_STORE = 2'd2
    } ex_op_t;

    // a memory address split into a word index and the offset in the word.
    typedef struct packed {
        logic [29:0] word_index;
        logic [1:0]  byte_offset;
    } mem_addr_t;

    // the result word of the execute stage is an ALU value for ALU operations
    // and an effective address for loads and stores.
    typedef union packed {
        logic [31:0] alu_value;
        mem_addr_t   mem_addr;
    } result_word_u;

    typedef struct packed {
        ex_op_t       op;
        logic [4:0]   dest_reg;
        result_word_u result;
        logic [31:0]  store_data;
    } ex_packet_t;

endpackage

// File: design/ex_mem_top.sv
`timescale 1ns/1ns

module ex_mem_top
    import ex_mem_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  logic        lane0_valid,
    input  ex_packet_t  lane0_packet,
    input  logic        lane1_valid,
    input  ex_packet_t  lane1_packet,
    output logic        stall,
    output logic        wb_valid,
    output logic [4:0]  wb_dest,
    output logic [31:0] wb_value,
    output logic        wb_error
);

    // ********************************************************************
    // FIFO to memory stage handshake
    // ********************************************************************

    logic       head_valid;
    ex_packet_t head_packet;
    logic       pop;

    // ********************************************************************
    // Wishbone bus and timer
    // ********************************************************************

    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [29:0] wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;
    logic        timer_run;
    logic        expired;

    ex_merge_fifo fifo_i (
        .clock        (clock),
        .reset        (reset),
        .lane0_valid  (lane0_valid),
        .lane0_packet (lane0_packet),
        .lane1_valid  (lane1_valid),
        .lane1_packet (lane1_packet),
        .pop          (pop),
        .stall        (stall),
        .head_valid   (head_valid),
        .head_packet  (head_packet)
    );

    mem_stage_fsm fsm_i (
        .clock       (clock),
        .reset       (reset),
        .head_valid  (head_valid),
        .head_packet (head_packet),
        .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack),
        .expired     (expired),
        .pop         (pop),
        .timer_run   (timer_run),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .wb_valid    (wb_valid),
        .wb_dest     (wb_dest),
        .wb_value    (wb_value),
        .wb_error    (wb_error)
    );

    bus_timeout_timer timer_i (
        .clock     (clock),
        .reset     (reset),
        .timer_run (timer_run),
        .expired   (expired)
    );

    data_mem_wb mem_i (
        .clock    (clock),
        .reset    (reset),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

endmodule

// File: design/ex_merge_fifo.sv
`timescale 1ns/1ns
`include "ex_mem_defs.svh"

module ex_merge_fifo
    import ex_mem_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       lane0_valid,
    input  ex_packet_t lane0_packet,
    input  logic       lane1_valid,
    input  ex_packet_t lane1_packet,
    input  logic       pop,
    output logic       stall,
    output logic       head_valid,
    output ex_packet_t head_packet
);

    localparam int PTR_W = $clog2(`FIFO_DEPTH);
    localparam int CNT_W = $clog2(`FIFO_DEPTH + 1);

    ex_packet_t       slots [`FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [PTR_W-1:0] wr_ptr_plus1;
    logic [PTR_W-1:0] wr_ptr_plus2;
    logic [PTR_W-1:0] lane1_slot;
    logic             wr0;
    logic             wr1;
    logic             pop_fire;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(`FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // the execute side must not present packets while stall is high.
    assign wr0 = lane0_valid && !stall;
    assign wr1 = lane1_valid && !stall;
    assign pop_fire = pop && head_valid;

    assign wr_ptr_plus1 = ptr_inc(wr_ptr);
    assign wr_ptr_plus2 = ptr_inc(wr_ptr_plus1);

    // lane 1 lands behind lane 0 so that program order is kept.
    assign lane1_slot = wr0 ? wr_ptr_plus1 : wr_ptr;

    // two free slots are needed to take a full dual-lane write.
    assign stall = (count > CNT_W'(`FIFO_DEPTH - 2));
    assign head_valid = (count != '0);
    assign head_packet = slots[rd_ptr];

    always_ff @(posedge clock) begin
        if (wr0) begin
            slots[wr_ptr] <= lane0_packet;
        end
        if (wr1) begin
            slots[lane1_slot] <= lane1_packet;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr0 && wr1) begin
                wr_ptr <= wr_ptr_plus2;
            end else if (wr0 || wr1) begin
                wr_ptr <= wr_ptr_plus1;
            end
            if (pop_fire) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count <= count + CNT_W'(wr0) + CNT_W'(wr1) - CNT_W'(pop_fire);
        end
    end

endmodule

// File: design/mem_stage_fsm.sv
`timescale 1ns/1ns

module mem_stage_fsm
    import ex_mem_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  logic        head_valid,
    input  ex_packet_t  head_packet,
    input  logic [31:0] wb_dat_r,
    input  logic        wb_ack,
    input  logic        expired,
    output logic        pop,
    output logic        timer_run,
    output logic        wb_cyc,
    output logic        wb_stb,
    output logic        wb_we,
    output logic [29:0] wb_adr,
    output logic [31:0] wb_dat_w,
    output logic        wb_valid,
    output logic [4:0]  wb_dest,
    output logic [31:0] wb_value,
    output logic        wb_error
);

    localparam logic [1:0] IDLE   = 2'd0;
    localparam logic [1:0] BUS    = 2'd1;
    localparam logic [1:0] FINISH = 2'd2;

    logic [1:0]  state;
    logic [1:0]  state_next;
    ex_packet_t  pkt_q;
    logic [31:0] value_q;
    logic        error_q;
    logic        head_misaligned;

    // loads and stores are word accesses, so any byte offset is rejected.
    assign head_misaligned = (head_packet.op != OP_ALU) &&
                             (head_packet.result.mem_addr.byte_offset != 2'b00);

    assign pop = (state == IDLE) && head_valid;
    assign timer_run = (state == BUS);

    assign wb_cyc = (state == BUS);
    assign wb_stb = (state == BUS);
    assign wb_we = (pkt_q.op == OP_STORE);
    assign wb_adr = pkt_q.result.mem_addr.word_index;
    assign wb_dat_w = pkt_q.store_data;

    assign wb_valid = (state == FINISH) && !error_q;
    assign wb_error = (state == FINISH) && error_q;
    assign wb_dest = pkt_q.dest_reg;
    assign wb_value = value_q;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (head_valid) begin
                    if (head_packet.op == OP_ALU || head_misaligned) begin
                        state_next = FINISH;
                    end else begin
                        state_next = BUS;
                    end
                end
            end
            BUS: begin
                // an acknowledge wins over a timeout in the same cycle.
                if (wb_ack) begin
                    state_next = (pkt_q.op == OP_STORE) ? IDLE : FINISH;
                end else if (expired) begin
                    state_next = FINISH;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state   <= IDLE;
            error_q <= 1'b0;
        end else begin
            state <= state_next;
            if (pop) begin
                error_q <= head_misaligned;
            end else if (state == BUS && !wb_ack && expired) begin
                error_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (pop) begin
            pkt_q   <= head_packet;
            value_q <= head_packet.result.alu_value;
        end else if (state == BUS && wb_ack) begin
            value_q <= wb_dat_r;
        end
    end

endmodule

// File: ex_mem.f
+incdir+include
design/ex_mem_pkg.sv
design/ex_merge_fifo.sv
design/mem_stage_fsm.sv
design/bus_timeout_timer.sv
design/data_mem_wb.sv
design/ex_mem_top.sv
tests/ex_mem_tb.sv

// File: include/ex_mem_defs.svh
`ifndef EX_MEM_DEFS_SVH
`define EX_MEM_DEFS_SVH

// ********************************************************************
// sizing of the execute-to-memory stage
// ********************************************************************

// packet slots in the merge FIFO.
`define FIFO_DEPTH 8

// words in the data memory behind the Wishbone bus.
`define MEM_WORDS 64

// cycles from the first strobe to the acknowledge of the memory.
`define MEM_WAIT 2

// wait cycles after which the memory stage gives up on a bus cycle.
`define BUS_TIMEOUT 16

`endif

// File: tests/ex_mem_tb.sv
`timescale 1ns/1ns
`include "ex_mem_defs.svh"

module ex_mem_tb
    import ex_mem_pkg::*;
;

    localparam int STALL_LIMIT = 400;
    localparam int DRAIN_LIMIT = 4000;
    localparam int RANDOM_CYCLES = 300;

    typedef enum logic [1:0] {
        KIND_NONE,
        KIND_WRITEBACK,
        KIND_ERROR
    } result_kind_t;

    typedef struct {
        result_kind_t kind;
        ex_packet_t   pkt;
    } expected_t;

    logic        clock;
    logic        reset;
    logic        lane0_valid;
    ex_packet_t  lane0_packet;
    logic        lane1_valid;
    ex_packet_t  lane1_packet;
    logic        stall;
    logic        wb_valid;
    logic [4:0]  wb_dest;
    logic [31:0] wb_value;
    logic        wb_error;

    logic [15:0] lfsr_state;
    logic [31:0] model_mem [`MEM_WORDS];
    expected_t   expected_q [$];
    logic        stall_seen;

    ex_mem_top dut_i (
        .clock        (clock),
        .reset        (reset),
        .lane0_valid  (lane0_valid),
        .lane0_packet (lane0_packet),
        .lane1_valid  (lane1_valid),
        .lane1_packet (lane1_packet),
        .stall        (stall),
        .wb_valid     (wb_valid),
        .wb_dest      (wb_dest),
        .wb_value     (wb_value),
        .wb_error     (wb_error)
    );

    always #5 clock = ~clock;

    // **********************************************************************
    // failure reporting and compare tasks
    // **********************************************************************

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("CHECK FAILED at %0t ns: %s expected 0x%08h got 0x%08h",
                 $time, name, expected, actual);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic fail_plain(input string why);
        $display("ERROR at %0t ns: %s", $time, why);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_writeback(input ex_packet_t expected);
        if (wb_error !== 1'b0) report_mismatch("wb_error", 32'd0, 32'(wb_error));
        if (wb_dest !== expected.dest_reg) begin
            report_mismatch("wb_dest", 32'(expected.dest_reg), 32'(wb_dest));
        end
        if (wb_value !== expected.result.alu_value) begin
            report_mismatch("wb_value", expected.result.alu_value, wb_value);
        end
    endtask

    task automatic check_error();
        if (wb_error !== 1'b1) report_mismatch("wb_error", 32'd1, 32'(wb_error));
        if (wb_valid !== 1'b0) report_mismatch("wb_valid", 32'd0, 32'(wb_valid));
    endtask

    // **********************************************************************
    // random numbers and the reference model
    // **********************************************************************

    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    task automatic take_bits(input int count, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits = {bits[30:0], lfsr_state[0]};
        end
    endtask

    // loads and stores must be word aligned and inside the memory, else they fail.
    function automatic result_kind_t ref_result(input ex_packet_t pkt,
                                                inout logic [31:0] mem [`MEM_WORDS],
                                                output logic [31:0] value);
        logic [29:0] idx;
        value = '0;
        idx = pkt.result.mem_addr.word_index;
        if (pkt.op == OP_ALU) begin
            value = pkt.result.alu_value;
            return KIND_WRITEBACK;
        end
        if (pkt.result.mem_addr.byte_offset != 2'b00 || idx >= 30'(`MEM_WORDS)) begin
            return KIND_ERROR;
        end
        if (pkt.op == OP_STORE) begin
            mem[int'(idx)] = pkt.store_data;
            return KIND_NONE;
        end
        value = mem[int'(idx)];
        return KIND_WRITEBACK;
    endfunction

    task automatic queue_expected(input ex_packet_t pkt);
        expected_t    entry;
        logic [31:0]  value;
        result_kind_t kind;
        kind = ref_result(pkt, model_mem, value);
        // stores produce no result, so they never enter the queue.
        if (kind != KIND_NONE) begin
            entry.kind = kind;
            entry.pkt = pkt;
            entry.pkt.result.alu_value = value;
            expected_q.push_back(entry);
        end
    endtask

    task automatic random_packet(output ex_packet_t pkt);
        logic [31:0] sel;
        logic [31:0] bits;
        pkt = '0;
        take_bits(2, sel);
        case (sel[1:0])
            2'd1: pkt.op = OP_LOAD;
            2'd2: pkt.op = OP_STORE;
            default: pkt.op = OP_ALU;
        endcase
        take_bits(5, bits);
        pkt.dest_reg = bits[4:0];
        take_bits(32, bits);
        pkt.store_data = bits;
        if (pkt.op == OP_ALU) begin
            take_bits(32, bits);
            pkt.result.alu_value = bits;
        end else begin
            take_bits(4, sel);
            take_bits(6, bits);
            pkt.result.mem_addr.word_index = 30'(bits[5:0]);
            // one in sixteen out of range, two in sixteen misaligned.
            if (sel[3:0] == 4'd0) begin
                pkt.result.mem_addr.word_index = 30'(`MEM_WORDS) + 30'(bits[5:0]);
            end else if (sel[3:0] < 4'd3) begin
                take_bits(2, bits);
                pkt.result.mem_addr.byte_offset = (bits[1:0] == 2'b00) ? 2'b11 : bits[1:0];
            end
        end
    endtask

    // **********************************************************************
    // stimulus
    // **********************************************************************

    task automatic send_pair(input logic v0, input ex_packet_t p0,
                             input logic v1, input ex_packet_t p1);
        int waited;
        waited = 0;
        @(negedge clock);
        while (stall) begin
            stall_seen = 1'b1;
            lane0_valid = 1'b0;
            lane1_valid = 1'b0;
            waited++;
            if (waited > STALL_LIMIT) fail_plain("stall stayed high and never cleared");
            @(negedge clock);
        end
        lane0_valid = v0;
        lane0_packet = p0;
        lane1_valid = v1;
        lane1_packet = p1;
        if (v0) queue_expected(p0);
        if (v1) queue_expected(p1);
    endtask

    function automatic ex_packet_t mem_packet(input ex_op_t op, input logic [4:0] dest,
                                              input logic [29:0] idx, input logic [31:0] data);
        ex_packet_t pkt;
        pkt = '0;
        pkt.op = op;
        pkt.dest_reg = dest;
        pkt.result.mem_addr.word_index = idx;
        pkt.store_data = data;
        return pkt;
    endfunction

    always @(posedge clock) begin : compare_results
        expected_t entry;
        if (!reset && (wb_valid === 1'b1 || wb_error === 1'b1)) begin
            if (expected_q.size() == 0) fail_plain("result seen with no packet pending");
            entry = expected_q.pop_front();
            if (entry.kind == KIND_WRITEBACK) begin
                check_writeback(entry.pkt);
            end else begin
                check_error();
            end
        end
    end

    initial begin
        ex_packet_t p0;
        ex_packet_t p1;
        logic [31:0] bits;
        int waited;
        clock = 1'b0;
        reset = 1'b1;
        lane0_valid = 1'b0;
        lane0_packet = '0;
        lane1_valid = 1'b0;
        lane1_packet = '0;
        lfsr_state = 16'd19;
        stall_seen = 1'b0;
        for (int i = 0; i < `MEM_WORDS; i++) begin
            model_mem[i] = '0;
        end
        repeat (5) @(negedge clock);
        reset = 1'b0;
        if (stall !== 1'b0) report_mismatch("stall", 32'd0, 32'(stall));
        if (wb_valid !== 1'b0) report_mismatch("wb_valid", 32'd0, 32'(wb_valid));
        if (wb_error !== 1'b0) report_mismatch("wb_error", 32'd0, 32'(wb_error));

        // a store and its load in one cycle, then a load of a fresh word.
        send_pair(1'b1, mem_packet(OP_STORE, 5'd1, 30'd5, 32'hCAFE_0005),
                  1'b1, mem_packet(OP_LOAD, 5'd2, 30'd5, 32'h0));
        send_pair(1'b1, mem_packet(OP_LOAD, 5'd3, 30'd9, 32'h0),
                  1'b0, '0);

        // a rejected load and a timed-out store leave word 5 as it was.
        p0 = mem_packet(OP_LOAD, 5'd4, 30'd5, 32'h0);
        p0.result.mem_addr.byte_offset = 2'b10;
        p1 = mem_packet(OP_STORE, 5'd5, 30'(`MEM_WORDS) + 30'd5, 32'hDEAD_0005);
        send_pair(1'b1, p0, 1'b1, p1);
        send_pair(1'b1, mem_packet(OP_LOAD, 5'd6, 30'd5, 32'h0),
                  1'b0, '0);

        for (int cycle = 0; cycle < RANDOM_CYCLES; cycle++) begin
            random_packet(p0);
            random_packet(p1);
            take_bits(2, bits);
            send_pair(bits[0] | bits[1], p0, bits[1], p1);
        end

        @(negedge clock);
        lane0_valid = 1'b0;
        lane1_valid = 1'b0;
        waited = 0;
        while (expected_q.size() != 0) begin
            waited++;
            if (waited > DRAIN_LIMIT) fail_plain("pending results never arrived");
            @(negedge clock);
        end
        repeat (`BUS_TIMEOUT + 8) @(negedge clock);

        if (!stall_seen) begin
            fail_plain("the dual-lane traffic never raised stall");
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule
